//--- design/mfpu_cfg.svh
// Configuration macros for the vector multiply unit
// Queue depths, multiplier stages, data and address widths

`ifndef MFPU_CFG_SVH
`define MFPU_CFG_SVH

// Lane datapath
`define MFPU_ELEN 64
`define MFPU_STRB 8

// Queue depths
`define MFPU_INSN_DEPTH 4
`define MFPU_RESQ_DEPTH 2

// Pipeline registers inside the multiplier
`define MFPU_MUL_STAGES 2

// Instruction ids, vector length and register file geometry
`define MFPU_NR_VINSN 8
`define MFPU_VL_W 7
`define MFPU_VREG_WORDS 8
`define MFPU_ADDR_W 8

`endif

//--- design/mfpu_pkg.sv
// Types of the vector multiply unit
// Element width and opcode enums, field types, instruction struct

`default_nettype none

`include "mfpu_cfg.svh"

package mfpu_pkg;

  // Element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Operations handled by this unit
  typedef enum logic [2:0] {
    VMUL    = 3'd0,
    VMULH   = 3'd1,
    VMULHU  = 3'd2,
    VMULHSU = 3'd3,
    VMACC   = 3'd4,
    VNMSAC  = 3'd5
  } mul_op_e;

  typedef logic [$clog2(`MFPU_NR_VINSN)-1:0] vid_t;
  typedef logic [4:0]                        vreg_t;
  typedef logic [`MFPU_VL_W-1:0]             vlen_t;
  // Elements in one word, up to ELEN/8
  typedef logic [$clog2(`MFPU_STRB):0]       ecnt_t;

  // One queued vector instruction
  typedef struct packed {
    mul_op_e op;
    vew_e    sew;
    vlen_t   vl;
    vreg_t   vd;
    vid_t    id;
  } vinsn_t;

endpackage

`default_nettype wire

//--- design/mfpu_beat_if.sv
// Beat interface between the pipeline stages
// One 64-bit word with its operands or result and its instruction tag

`timescale 1ns/1ps
`default_nettype none

`include "mfpu_cfg.svh"

interface mfpu_beat_if;

  // Handshake
  logic                          valid;
  logic                          ready;
  // vs1, vs2, vd on the request side
  // Word 0 holds the result on the response side
  logic [2:0][`MFPU_ELEN-1:0]    operand;
  mfpu_pkg::mul_op_e             op;
  mfpu_pkg::vew_e                sew;
  // Tag of the owning instruction
  mfpu_pkg::vid_t                id;
  mfpu_pkg::vreg_t               vd;
  mfpu_pkg::ecnt_t               elem_cnt;
  mfpu_pkg::vlen_t               word_idx;
  logic                          last;

  modport src (
    output valid, operand, op, sew, id, vd, elem_cnt, word_idx, last,
    input  ready
  );

  modport dst (
    input  valid, operand, op, sew, id, vd, elem_cnt, word_idx, last,
    output ready
  );

endinterface

`default_nettype wire

//--- design/mfpu_issue.sv
// Issue stage of the vector multiply unit
// In-order instruction queue, element countdown of the head instruction
// and operand acknowledge towards the operand queues

`timescale 1ns/1ps
`default_nettype none

`include "mfpu_cfg.svh"

module mfpu_issue (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Instruction side
  input  logic                       insn_valid_i,
  input  mfpu_pkg::mul_op_e          insn_op_i,
  input  mfpu_pkg::vew_e             insn_sew_i,
  input  mfpu_pkg::vlen_t            insn_vl_i,
  input  mfpu_pkg::vreg_t            insn_vd_i,
  input  mfpu_pkg::vid_t             insn_id_i,
  output logic                       insn_ready_o,
  // Operand queues, 0 is vs1, 1 is vs2, 2 is vd
  input  logic [2:0][`MFPU_ELEN-1:0] operand_i,
  input  logic [2:0]                 operand_valid_i,
  output logic [2:0]                 operand_ready_o,
  // Towards the multiplier
  mfpu_beat_if.src                   mul_req
);

  localparam int unsigned DEPTH = `MFPU_INSN_DEPTH;
  localparam int unsigned PW    = $clog2(DEPTH);

  // Circular instruction queue with accept and issue pointers and a fill count
  mfpu_pkg::vinsn_t queue_q [DEPTH];
  logic [PW-1:0]    accept_pnt_q;
  logic [PW-1:0]    issue_pnt_q;
  logic [PW:0]      cnt_q;
  // Elements of the head instruction already sent
  mfpu_pkg::vlen_t  issued_q;

  mfpu_pkg::vinsn_t head;
  logic             head_valid;
  logic             use_vd;
  logic             accept;
  logic             xfer;
  logic             pop;
  logic [1:0]       lg_per_word;
  mfpu_pkg::ecnt_t  per_word;
  mfpu_pkg::vlen_t  remaining;

  function automatic logic [PW-1:0] bump(input logic [PW-1:0] pnt);
    return (pnt == PW'(DEPTH - 1)) ? '0 : pnt + 1'b1;
  endfunction

  assign insn_ready_o = (cnt_q != (PW+1)'(DEPTH));
  assign accept       = insn_valid_i && insn_ready_o;

  assign head       = queue_q[issue_pnt_q];
  assign head_valid = (cnt_q != '0);
  // Only the accumulate ops read the old destination
  assign use_vd     = head.op inside {mfpu_pkg::VMACC, mfpu_pkg::VNMSAC};

  // Elements per word are 8 >> sew
  assign lg_per_word = 2'd3 - head.sew;
  assign per_word    = mfpu_pkg::ecnt_t'(1) << lg_per_word;
  assign remaining   = head.vl - issued_q;

  // Beat valid once every needed operand is present
  assign mul_req.valid = head_valid && operand_valid_i[0] && operand_valid_i[1] &&
                         (operand_valid_i[2] || !use_vd);
  assign xfer = mul_req.valid && mul_req.ready;
  assign pop  = xfer && mul_req.last;

  // Acknowledge in the transfer cycle
  assign operand_ready_o = xfer ? {use_vd, 2'b11} : 3'b000;

  // Beat payload
  assign mul_req.operand  = operand_i;
  assign mul_req.op       = head.op;
  assign mul_req.sew      = head.sew;
  assign mul_req.id       = head.id;
  assign mul_req.vd       = head.vd;
  assign mul_req.last     = (remaining <= mfpu_pkg::vlen_t'(per_word));
  // Tail word carries only what is left
  assign mul_req.elem_cnt = mul_req.last ? mfpu_pkg::ecnt_t'(remaining) : per_word;
  assign mul_req.word_idx = issued_q >> lg_per_word;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      queue_q[accept_pnt_q] <= '{op: insn_op_i, sew: insn_sew_i, vl: insn_vl_i,
                                 vd: insn_vd_i, id: insn_id_i};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      cnt_q        <= '0;
      issued_q     <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= bump(accept_pnt_q);
      end
      if (xfer) begin
        if (mul_req.last) begin
          // Next instruction starts from element 0
          issued_q    <= '0;
          issue_pnt_q <= bump(issue_pnt_q);
        end else begin
          issued_q <= issued_q + mfpu_pkg::vlen_t'(per_word);
        end
      end
      case ({accept, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // A beat only leaves for a queued instruction and never runs past its vl
  // Queue occupancy is taken from the pointers, apart from the fill count
  a_issue_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mul_req.valid |-> ((accept_pnt_q != issue_pnt_q) || (cnt_q == (PW+1)'(DEPTH))) &&
      (issued_q < head.vl))
    else $error("issue beat without a live instruction");

endmodule

`default_nettype wire

//--- design/mfpu_simd_mul.sv
// Pipelined SIMD multiplier of the vector multiply unit
// Stalling shift register of beats and per-lane arithmetic
// selected by the element width of each beat

`timescale 1ns/1ps
`default_nettype none

`include "mfpu_cfg.svh"

module mfpu_simd_mul (
  input  logic     clk_i,
  input  logic     rst_ni,
  mfpu_beat_if.dst in,
  mfpu_beat_if.src out
);

  localparam int unsigned S  = `MFPU_MUL_STAGES;
  localparam int unsigned EL = `MFPU_ELEN;

  // Everything a beat carries through the stages
  typedef struct packed {
    logic [2:0][EL-1:0] operand;
    mfpu_pkg::mul_op_e  op;
    mfpu_pkg::vew_e     sew;
    mfpu_pkg::vid_t     id;
    mfpu_pkg::vreg_t    vd;
    mfpu_pkg::ecnt_t    elem_cnt;
    mfpu_pkg::vlen_t    word_idx;
    logic               last;
  } beat_t;

  beat_t             in_beat;
  beat_t             stage_q [S];
  logic [S-1:0]      valid_q;
  logic [S-1:0]      stage_en;
  beat_t             tail;
  logic              sign_a;
  logic              sign_b;
  // One result word per element width
  wire [3:0][EL-1:0] res_w;

  assign in_beat = '{operand: in.operand, op: in.op, sew: in.sew, id: in.id, vd: in.vd,
                     elem_cnt: in.elem_cnt, word_idx: in.word_idx, last: in.last};

  // Ready ripples back from the output
  // A stage holding a bubble may always load
  always_comb begin
    logic nxt;
    nxt = out.ready;
    for (int i = S - 1; i >= 0; i--) begin
      stage_en[i] = nxt | ~valid_q[i];
      nxt         = stage_en[i];
    end
  end

  assign in.ready = stage_en[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      if (stage_en[0]) begin
        valid_q[0] <= in.valid;
      end
      for (int i = 1; i < S; i++) begin
        if (stage_en[i]) begin
          valid_q[i] <= valid_q[i-1];
        end
      end
    end
  end

  // Payload moves with the same enables
  always_ff @(posedge clk_i) begin
    if (stage_en[0]) begin
      stage_q[0] <= in_beat;
    end
    for (int i = 1; i < S; i++) begin
      if (stage_en[i]) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign tail = stage_q[S-1];

  // vs1 signed only for VMULH, vs2 signed for VMULH and VMULHSU
  assign sign_a = (tail.op == mfpu_pkg::VMULH);
  assign sign_b = tail.op inside {mfpu_pkg::VMULH, mfpu_pkg::VMULHSU};

  for (genvar g = 0; g < 4; g++) begin : gen_ew
    localparam int unsigned EW = 8 << g;
    for (genvar l = 0; l < EL / EW; l++) begin : gen_lane
      logic [EW-1:0]          a;
      logic [EW-1:0]          b;
      logic [EW-1:0]          c;
      logic [EW-1:0]          lo;
      logic [EW-1:0]          hi;
      logic signed [EW:0]     a_ext;
      logic signed [EW:0]     b_ext;
      logic signed [2*EW+1:0] prod;

      assign a = tail.operand[0][l*EW +: EW];
      assign b = tail.operand[1][l*EW +: EW];
      assign c = tail.operand[2][l*EW +: EW];
      // Extra top bit turns both signed and unsigned into one signed multiply
      assign a_ext = $signed({a[EW-1] & sign_a, a});
      assign b_ext = $signed({b[EW-1] & sign_b, b});
      assign prod  = a_ext * b_ext;
      assign lo    = prod[EW-1:0];
      assign hi    = prod[2*EW-1:EW];

      assign res_w[g][l*EW +: EW] = (tail.op == mfpu_pkg::VMUL)   ? lo :
                                    (tail.op == mfpu_pkg::VMACC)  ? lo + c :
                                    (tail.op == mfpu_pkg::VNMSAC) ? c - lo : hi;
    end
  end

  // Output beat, result in word 0
  assign out.valid    = valid_q[S-1];
  assign out.operand  = {{(2*EL){1'b0}}, res_w[tail.sew]};
  assign out.op       = tail.op;
  assign out.sew      = tail.sew;
  assign out.id       = tail.id;
  assign out.vd       = tail.vd;
  assign out.elem_cnt = tail.elem_cnt;
  assign out.word_idx = tail.word_idx;
  assign out.last     = tail.last;

  // A stalled result stays put until commit takes it
  a_mul_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out.valid && !out.ready |=> out.valid && $stable(out.operand[0]) &&
      $stable(out.id) && $stable(out.word_idx) && $stable(out.last))
    else $error("multiplier output changed under stall");

endmodule

`default_nettype wire

//--- design/mfpu_commit.sv
// Commit stage of the vector multiply unit
// Two-entry result queue, address and byte enable generation,
// register file write request and done pulse

`timescale 1ns/1ps
`default_nettype none

`include "mfpu_cfg.svh"

module mfpu_commit (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  mfpu_beat_if.dst                     in,
  // Register file side
  output logic                         result_req_o,
  output logic [`MFPU_ADDR_W-1:0]      result_addr_o,
  output mfpu_pkg::vid_t               result_id_o,
  output logic [`MFPU_ELEN-1:0]        result_wdata_o,
  output logic [`MFPU_STRB-1:0]        result_be_o,
  input  logic                         result_gnt_i,
  output logic [`MFPU_NR_VINSN-1:0]    vinsn_done_o
);

  localparam int unsigned DEPTH = `MFPU_RESQ_DEPTH;
  localparam int unsigned PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned AW    = `MFPU_ADDR_W;
  localparam int unsigned SB    = `MFPU_STRB;

  typedef struct packed {
    mfpu_pkg::vid_t         id;
    logic [AW-1:0]          addr;
    logic [`MFPU_ELEN-1:0]  wdata;
    logic [SB-1:0]          be;
    logic                   last;
  } res_t;

  res_t                   resq_q [DEPTH];
  logic [PW-1:0]          wr_pnt_q;
  logic [PW-1:0]          rd_pnt_q;
  logic [$clog2(DEPTH):0] cnt_q;

  res_t                   entry;
  res_t                   head;
  logic [3:0]             nbytes;
  logic                   push;
  logic                   pop;

  function automatic logic [PW-1:0] bump(input logic [PW-1:0] pnt);
    return (pnt == PW'(DEPTH - 1)) ? '0 : pnt + 1'b1;
  endfunction

  // Accept while a slot is free
  assign in.ready = (cnt_q != ($clog2(DEPTH)+1)'(DEPTH));
  assign push     = in.valid && in.ready;
  assign pop      = result_gnt_i;

  // Bytes written equal element count times element size
  assign nbytes = 4'(in.elem_cnt << in.sew);

  assign entry.id    = in.id;
  // Words of one register are contiguous
  assign entry.addr  = AW'(in.vd) * AW'(`MFPU_VREG_WORDS) + AW'(in.word_idx);
  assign entry.wdata = in.operand[0];
  assign entry.be    = ~({SB{1'b1}} << nbytes);
  assign entry.last  = in.last;

  // Register file request from the oldest entry
  assign head           = resq_q[rd_pnt_q];
  assign result_req_o   = (cnt_q != '0);
  assign result_addr_o  = head.addr;
  assign result_id_o    = head.id;
  assign result_wdata_o = head.wdata;
  assign result_be_o    = head.be;

  // Done pulse on the grant of the final word
  always_comb begin
    vinsn_done_o = '0;
    if (pop && head.last) begin
      vinsn_done_o[head.id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      resq_q[wr_pnt_q] <= entry;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_pnt_q <= bump(wr_pnt_q);
      end
      if (pop) begin
        rd_pnt_q <= bump(rd_pnt_q);
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Register file only grants a pending request
  a_gnt_with_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_gnt_i |-> result_req_o)
    else $error("result grant without request");

endmodule

`default_nettype wire

//--- design/mfpu_top.sv
// Top level of the vector multiply unit
// Issue, multiplier and commit linked by two beat interfaces

`timescale 1ns/1ps
`default_nettype none

`include "mfpu_cfg.svh"

module mfpu_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Instruction side
  input  logic                       insn_valid_i,
  input  mfpu_pkg::mul_op_e          insn_op_i,
  input  mfpu_pkg::vew_e             insn_sew_i,
  input  mfpu_pkg::vlen_t            insn_vl_i,
  input  mfpu_pkg::vreg_t            insn_vd_i,
  input  mfpu_pkg::vid_t             insn_id_i,
  output logic                       insn_ready_o,
  // Operand queues
  input  logic [2:0][`MFPU_ELEN-1:0] operand_i,
  input  logic [2:0]                 operand_valid_i,
  output logic [2:0]                 operand_ready_o,
  // Register file write port
  output logic                       result_req_o,
  output logic [`MFPU_ADDR_W-1:0]    result_addr_o,
  output mfpu_pkg::vid_t             result_id_o,
  output logic [`MFPU_ELEN-1:0]      result_wdata_o,
  output logic [`MFPU_STRB-1:0]      result_be_o,
  input  logic                       result_gnt_i,
  output logic [`MFPU_NR_VINSN-1:0]  vinsn_done_o
);

  // Issue to multiplier, multiplier to commit
  mfpu_beat_if mul_req ();
  mfpu_beat_if mul_rsp ();

  mfpu_issue u_issue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .insn_valid_i    (insn_valid_i),
    .insn_op_i       (insn_op_i),
    .insn_sew_i      (insn_sew_i),
    .insn_vl_i       (insn_vl_i),
    .insn_vd_i       (insn_vd_i),
    .insn_id_i       (insn_id_i),
    .insn_ready_o    (insn_ready_o),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .mul_req         (mul_req.src)
  );

  mfpu_simd_mul u_mul (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .in     (mul_req.dst),
    .out    (mul_rsp.src)
  );

  mfpu_commit u_commit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .in             (mul_rsp.dst),
    .result_req_o   (result_req_o),
    .result_addr_o  (result_addr_o),
    .result_id_o    (result_id_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i),
    .vinsn_done_o   (vinsn_done_o)
  );

endmodule

`default_nettype wire

//--- verif/tb_checker.sv
// Testbench scoreboard of the vector multiply unit
// Lane reference model, operand tracking and in-order compare of writes

`timescale 1ns/1ps
`default_nettype none

`include "mfpu_cfg.svh"

module tb_checker (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       insn_valid_i,
  input  mfpu_pkg::vinsn_t           insn_i,
  input  logic                       insn_ready_i,
  input  logic [2:0][`MFPU_ELEN-1:0] operand_i,
  input  logic [2:0]                 operand_ready_i,
  input  logic                       result_req_i,
  input  logic [`MFPU_ADDR_W-1:0]    result_addr_i,
  input  mfpu_pkg::vid_t             result_id_i,
  input  logic [`MFPU_ELEN-1:0]      result_wdata_i,
  input  logic [`MFPU_STRB-1:0]      result_be_i,
  input  logic                       result_gnt_i,
  input  logic [`MFPU_NR_VINSN-1:0]  vinsn_done_i,
  output int                         err_cnt_o,
  output int                         wr_cnt_o,
  output int                         done_cnt_o,
  output bit                         full_seen_o,
  output bit                         idle_o
);

  localparam int AW = `MFPU_ADDR_W;

  typedef struct packed {
    logic [AW-1:0]         addr;
    logic [`MFPU_ELEN-1:0] data;
    logic [`MFPU_STRB-1:0] be;
    mfpu_pkg::vid_t        id;
    logic                  last;
  } wr_t;

  // Instructions not yet fully acknowledged, and writes still due
  mfpu_pkg::vinsn_t ins_q[$];
  wr_t              exp_q[$];
  // Elements of the oldest instruction already acknowledged
  int               issued;

  // Expected result word, built lane by lane
  function automatic logic [63:0] expected_word(input mfpu_pkg::mul_op_e op, input int ew,
                                                input logic [63:0] a, input logic [63:0] b,
                                                input logic [63:0] c);
    logic [63:0]  mask;
    logic [63:0]  x;
    logic [63:0]  y;
    logic [63:0]  acc;
    logic [63:0]  r;
    logic [127:0] xs;
    logic [127:0] ys;
    logic [127:0] p;
    logic [63:0]  res;
    mask = (ew == 64) ? '1 : (64'd1 << ew) - 64'd1;
    res  = '0;
    for (int l = 0; l < 64 / ew; l++) begin
      x   = (a >> (l * ew)) & mask;
      y   = (b >> (l * ew)) & mask;
      acc = (c >> (l * ew)) & mask;
      xs  = {64'd0, x};
      ys  = {64'd0, y};
      // vs1 signed only in VMULH, vs2 signed in VMULH and VMULHSU
      if (op == mfpu_pkg::VMULH && x[ew-1]) begin
        xs = xs | ~{64'd0, mask};
      end
      if ((op == mfpu_pkg::VMULH || op == mfpu_pkg::VMULHSU) && y[ew-1]) begin
        ys = ys | ~{64'd0, mask};
      end
      // Low 128 bits of a two's complement product are exact here
      p = xs * ys;
      case (op)
        mfpu_pkg::VMUL:   r = p[63:0];
        mfpu_pkg::VMACC:  r = p[63:0] + acc;
        mfpu_pkg::VNMSAC: r = acc - p[63:0];
        default:          r = 64'(p >> ew);
      endcase
      res = res | ((r & mask) << (l * ew));
    end
    return res;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
    if (exp !== got) begin
      $display("MISMATCH %s exp 0x%0h got 0x%0h", name, exp, got);
      err_cnt_o++;
    end
  endtask

  always @(posedge clk_i) begin
    mfpu_pkg::vinsn_t          h;
    wr_t                       w;
    wr_t                       e;
    logic                      acc_op;
    logic [63:0]               bm;
    logic [`MFPU_NR_VINSN-1:0] done;
    int                        ew;
    int                        lanes;
    int                        n;
    if (rst_ni) begin
      // Instruction queue only refuses when four are waiting
      if (!insn_ready_i && ins_q.size() != `MFPU_INSN_DEPTH) begin
        $display("instruction refused with only %0d instructions queued", ins_q.size());
        err_cnt_o++;
      end
      if (!insn_ready_i) begin
        full_seen_o = 1'b1;
      end
      if (operand_ready_i != 3'b000) begin
        if (ins_q.size() == 0) begin
          $display("operands acknowledged with no instruction queued");
          err_cnt_o++;
        end else begin
          h      = ins_q[0];
          ew     = 8 << h.sew;
          lanes  = 64 / ew;
          acc_op = (h.op == mfpu_pkg::VMACC) || (h.op == mfpu_pkg::VNMSAC);
          compare_value("operand_ready_o", 64'({acc_op, 2'b11}), 64'(operand_ready_i));
          n      = (int'(h.vl) - issued < lanes) ? int'(h.vl) - issued : lanes;
          w.data = expected_word(h.op, ew, operand_i[0], operand_i[1], operand_i[2]);
          w.addr = AW'(int'(h.vd) * `MFPU_VREG_WORDS + issued / lanes);
          w.be   = `MFPU_STRB'((16'd1 << (n * ew / 8)) - 16'd1);
          w.id   = h.id;
          w.last = (issued + n >= int'(h.vl));
          exp_q.push_back(w);
          issued = w.last ? 0 : issued + n;
          if (w.last) begin
            void'(ins_q.pop_front());
          end
        end
      end
      if (insn_valid_i && insn_ready_i) begin
        ins_q.push_back(insn_i);
      end
      if (result_gnt_i && result_req_i) begin
        if (exp_q.size() == 0) begin
          $display("register file write granted with no result expected");
          err_cnt_o++;
        end else begin
          e = exp_q.pop_front();
          wr_cnt_o++;
          // Only enabled bytes carry data
          for (int k = 0; k < `MFPU_STRB; k++) begin
            bm[k*8 +: 8] = {8{e.be[k]}};
          end
          compare_value("result_addr_o", 64'(e.addr), 64'(result_addr_i));
          compare_value("result_be_o", 64'(e.be), 64'(result_be_i));
          compare_value("result_id_o", 64'(e.id), 64'(result_id_i));
          compare_value("result_wdata_o", e.data & bm, result_wdata_i & bm);
          done = e.last ? (`MFPU_NR_VINSN'(1) << e.id) : '0;
          compare_value("vinsn_done_o", 64'(done), 64'(vinsn_done_i));
          if (e.last && vinsn_done_i == done) begin
            done_cnt_o++;
          end
        end
      end else if (vinsn_done_i != '0) begin
        compare_value("vinsn_done_o", 64'd0, 64'(vinsn_done_i));
      end
      idle_o = (ins_q.size() == 0) && (exp_q.size() == 0);
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_top.sv
// Testbench top of the vector multiply unit
// Clock, reset, instruction plan, operand queue model, grant driver, timeout

`timescale 1ns/1ps
`default_nettype none

`include "mfpu_cfg.svh"

module tb_top;

  // DUT inputs start idle with reset held
  logic                       clk_i           = 1'b0;
  logic                       rst_ni          = 1'b0;
  logic                       insn_valid_i    = 1'b0;
  mfpu_pkg::vinsn_t           cur             = '0;
  logic [2:0][`MFPU_ELEN-1:0] operand_i       = '0;
  logic [2:0]                 operand_valid_i = '0;
  logic                       result_gnt_i    = 1'b0;

  mfpu_pkg::mul_op_e          insn_op_i;
  mfpu_pkg::vew_e             insn_sew_i;
  mfpu_pkg::vlen_t            insn_vl_i;
  mfpu_pkg::vreg_t            insn_vd_i;
  mfpu_pkg::vid_t             insn_id_i;
  logic                       insn_ready_o;
  logic [2:0]                 operand_ready_o;
  logic                       result_req_o;
  logic [`MFPU_ADDR_W-1:0]    result_addr_o;
  mfpu_pkg::vid_t             result_id_o;
  logic [`MFPU_ELEN-1:0]      result_wdata_o;
  logic [`MFPU_STRB-1:0]      result_be_o;
  logic [`MFPU_NR_VINSN-1:0]  vinsn_done_o;

  // Planned instructions and the three operand streams, vs1, vs2, vd
  mfpu_pkg::vinsn_t           plan_q[$];
  logic [`MFPU_ELEN-1:0]      opq [3][$];
  logic [2:0]                 taken = '0;
  int                         words;
  int                         limit;
  int                         cycles;
  int                         hold_at;
  int                         hold_until;
  int                         tb_errs;
  int                         err_cnt;
  int                         wr_cnt;
  int                         done_cnt;
  bit                         full_seen;
  bit                         idle;

  assign insn_op_i  = cur.op;
  assign insn_sew_i = cur.sew;
  assign insn_vl_i  = cur.vl;
  assign insn_vd_i  = cur.vd;
  assign insn_id_i  = cur.id;

  mfpu_top dut0 (.*);

  tb_checker u_checker (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .insn_valid_i    (insn_valid_i),
    .insn_i          (cur),
    .insn_ready_i    (insn_ready_o),
    .operand_i       (operand_i),
    .operand_ready_i (operand_ready_o),
    .result_req_i    (result_req_o),
    .result_addr_i   (result_addr_o),
    .result_id_i     (result_id_o),
    .result_wdata_i  (result_wdata_o),
    .result_be_i     (result_be_o),
    .result_gnt_i    (result_gnt_i),
    .vinsn_done_i    (vinsn_done_o),
    .err_cnt_o       (err_cnt),
    .wr_cnt_o        (wr_cnt),
    .done_cnt_o      (done_cnt),
    .full_seen_o     (full_seen),
    .idle_o          (idle)
  );

  initial begin
    forever #20 clk_i = ~clk_i;
  end

  // Queue one instruction with random words for each operand it reads
  task automatic plan_insn(input mfpu_pkg::mul_op_e op, input mfpu_pkg::vew_e sew,
                           input int vl);
    int lanes;
    lanes = 8 >> sew;
    plan_q.push_back('{op: op, sew: sew, vl: mfpu_pkg::vlen_t'(vl),
                       vd: mfpu_pkg::vreg_t'($urandom_range(0, 31)),
                       id: mfpu_pkg::vid_t'(plan_q.size())});
    for (int w = 0; w < (vl + lanes - 1) / lanes; w++) begin
      opq[0].push_back({$urandom, $urandom});
      opq[1].push_back({$urandom, $urandom});
      if (op == mfpu_pkg::VMACC || op == mfpu_pkg::VNMSAC) begin
        opq[2].push_back({$urandom, $urandom});
      end
      words++;
    end
  endtask

  // Hold the instruction until an accepting edge
  task automatic send_insn(input mfpu_pkg::vinsn_t ins);
    cur          = ins;
    insn_valid_i = 1'b1;
    @(posedge clk_i);
    while (!insn_ready_o) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    insn_valid_i = 1'b0;
  endtask

  initial begin
    int s;
    void'($urandom(32'hfc5e7545));
    // Every op at every width, two full words each
    for (int o = 0; o < 6; o++) begin
      for (s = 0; s < 4; s++) begin
        plan_insn(mfpu_pkg::mul_op_e'(o), mfpu_pkg::vew_e'(s), 2 * (8 >> s));
      end
    end
    // Partial tail words
    plan_insn(mfpu_pkg::VMUL, mfpu_pkg::EW16, 5);
    plan_insn(mfpu_pkg::VMACC, mfpu_pkg::EW8, 13);
    plan_insn(mfpu_pkg::VNMSAC, mfpu_pkg::EW32, 3);
    plan_insn(mfpu_pkg::VMULHSU, mfpu_pkg::EW64, 1);
    plan_insn(mfpu_pkg::VMULH, mfpu_pkg::EW8, 7);
    // Burst sent while grants are held off
    hold_at = plan_q.size();
    for (int i = 0; i < 6; i++) begin
      s = $urandom_range(0, 3);
      plan_insn(mfpu_pkg::mul_op_e'($urandom_range(0, 5)), mfpu_pkg::vew_e'(s), 2 * (8 >> s));
    end
    limit = 40 * words + 200;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    foreach (plan_q[i]) begin
      if (i == hold_at) begin
        hold_until = cycles + 50;
      end
      send_insn(plan_q[i]);
    end
    wait (wr_cnt == words && done_cnt == plan_q.size());
    repeat (4) @(negedge clk_i);
    if (!full_seen) begin
      $display("instruction queue never filled while grants were held");
      tb_errs++;
    end
    if (!idle || opq[0].size() != 0 || opq[1].size() != 0 || opq[2].size() != 0) begin
      $display("operands or expected writes left over at the end");
      tb_errs++;
    end
    $display("%0d instructions, %0d writes, %0d errors", plan_q.size(), wr_cnt,
             err_cnt + tb_errs);
    if (err_cnt + tb_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  always @(posedge clk_i) begin
    taken <= operand_valid_i & operand_ready_o;
  end

  // Each stream keeps its word valid until taken, with random gaps
  always @(negedge clk_i) begin
    for (int k = 0; k < 3; k++) begin
      if (taken[k]) begin
        void'(opq[k].pop_front());
        operand_valid_i[k] = 1'b0;
      end
      if (rst_ni && !operand_valid_i[k] && opq[k].size() > 0 && $urandom_range(0, 3) != 0) begin
        operand_i[k]       = opq[k][0];
        operand_valid_i[k] = 1'b1;
      end
    end
  end

  // Random grant delays, none during the hold window
  always @(negedge clk_i) begin
    result_gnt_i = result_req_o && (cycles >= hold_until) && ($urandom_range(0, 2) != 0);
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout after %0d cycles with %0d of %0d writes seen", cycles, wr_cnt, words);
      $display("%0d instructions, %0d writes, %0d errors", plan_q.size(), wr_cnt,
               err_cnt + tb_errs + 1);
      $display("TB FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+design
design/mfpu_pkg.sv
design/mfpu_beat_if.sv
design/mfpu_issue.sv
design/mfpu_simd_mul.sv
design/mfpu_commit.sv
design/mfpu_top.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the vector multiply unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f files.f \
  -Mdir obj_dir \
  && ./obj_dir/Vtb_top > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || exit 1
exit 0
